/* asa_cfg_pkg.sv */
// Width and depth constants of the replication to traffic manager adapter.
// Identifier widths, queue depths and the back-pressure thresholds.

`default_nettype none

package asa_cfg_pkg;

	// ==================================================
	// Identifier and field widths
	// ==================================================
	localparam int PACKET_ID_NBITS     = 6;   // 64 packets in flight.
	localparam int QID_NBITS           = 8;
	localparam int CONN_ID_NBITS       = 10;
	localparam int CONN_GROUP_NBITS    = 6;
	localparam int PORT_QUEUE_NBITS    = 5;
	localparam int PORT_ID_NBITS       = 4;
	localparam int BUF_PTR_NBITS       = 12;
	localparam int PACKET_LENGTH_NBITS = 14;
	localparam int READ_COUNT_NBITS    = 5;

	// ==================================================
	// Queue depths and back-pressure levels
	// ==================================================
	localparam int INTAKE_DEPTH_NBITS  = 4;
	localparam int PENDING_DEPTH_NBITS = 5;
	localparam int RELEASE_DEPTH_NBITS = 5;
	localparam int BP_ON_LEVEL         = 10;  // Raise rep_bp above this intake count.
	localparam int BP_OFF_LEVEL        = 6;   // Drop rep_bp below this intake count.

endpackage

`default_nettype wire

/* asa_checker.sv */
// Output checker of the adapter testbench.
// Compares polls, enqueues, releases and the back-pressure level with
// the golden expectations and keeps the pass and fail counts.

`default_nettype none

module asa_checker (
	input  wire logic                             clk,
	input  wire logic                             rst_n,
	input  wire logic                             poll_req,
	input  wire logic [asa_cfg_pkg::QID_NBITS-1:0] poll_qid,
	input  wire logic [asa_cfg_pkg::PORT_ID_NBITS-1:0] poll_src_port,
	input  wire logic                             tm_enq_req,
	input  wire asa_types_pkg::tm_enq_t           tm_enq,
	input  wire logic                             release_valid,
	input  wire asa_types_pkg::release_t          release_data,
	input  wire logic                             poll_ack,
	input  wire logic                             discard_req,
	input  wire logic                             rep_bp,
	input  wire logic                             bp_check,
	input  wire logic                             report_req,
	output logic                                  report_done,
	output int                                    pass_count,
	output int                                    fail_count
);

	import asa_cfg_pkg::*;
	import asa_types_pkg::*;

	logic [QID_NBITS+PORT_ID_NBITS-1:0] exp_poll[$];
	tm_enq_t  exp_enq[$];
	string    enq_name[$];
	release_t exp_rel[$];
	string    rel_name[$];
	string    bp_name[$];
	int         polls_checked;
	logic [2:0] ack_hist;
	logic [1:0] disc_hist;
	logic       bp_seen;

	task automatic load_expected();
		int       fd;
		int       code;
		int       v[8];
		string    tok;
		string    name;
		string    rest;
		tm_enq_t  e;
		release_t r;
		fd = $fopen("asa_golden.txt", "r");
		while (fd != 0 && !$feof(fd)) begin
			code = $fscanf(fd, "%s", tok);
			if (code != 1) begin
				break;
			end
			if (tok == "E") begin
				code = $fscanf(fd, "%s %h %h %h %h %h %h %h %h", name,
					v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7]);
				e.qid           = QID_NBITS'(v[0]);
				e.conn_id       = CONN_ID_NBITS'(v[1]);
				e.conn_group_id = CONN_GROUP_NBITS'(v[2]);
				e.port_queue_id = PORT_QUEUE_NBITS'(v[3]);
				e.desc.src_port = PORT_ID_NBITS'(v[4]);
				e.desc.dst_port = PORT_ID_NBITS'(v[5]);
				e.desc.buf_ptr  = BUF_PTR_NBITS'(v[6]);
				e.desc.length   = PACKET_LENGTH_NBITS'(v[7]);
				exp_enq.push_back(e);
				enq_name.push_back(name);
			end else if (tok == "R") begin
				code = $fscanf(fd, "%s %h %h %h %h", name, v[0], v[1], v[2], v[3]);
				r.read_count = READ_COUNT_NBITS'(v[0]);
				r.src_port   = PORT_ID_NBITS'(v[1]);
				r.buf_ptr    = BUF_PTR_NBITS'(v[2]);
				r.length     = PACKET_LENGTH_NBITS'(v[3]);
				exp_rel.push_back(r);
				rel_name.push_back(name);
			end else if (tok == "B") begin
				code = $fscanf(fd, "%s", name);
				bp_name.push_back(name);
			end else if (tok == "C") begin
				// Each copy is polled once, with its own qid and source port.
				code = $fscanf(fd, "%h %h %h %h %h %h", v[0], v[1], v[2], v[3], v[4], v[5]);
				exp_poll.push_back({QID_NBITS'(v[1]), PORT_ID_NBITS'(v[5])});
				code = $fgets(rest, fd);
			end else begin
				code = $fgets(rest, fd);
			end
		end
		if (fd != 0) begin
			$fclose(fd);
		end
	endtask

	task automatic note(input string name, input bit ok, input logic [63:0] exp_v,
			input logic [63:0] act_v);
		if (ok) begin
			pass_count++;
			$display("PASS %s", name);
		end else begin
			fail_count++;
			$display("Error %s: expected %h actual %h", name, exp_v, act_v);
		end
	endtask

	task automatic compare_poll();
		logic [QID_NBITS+PORT_ID_NBITS-1:0] p;
		string                              name;
		name = $sformatf("poll_%0d", polls_checked);
		polls_checked++;
		if (exp_poll.size() == 0) begin
			fail_count++;
			$display("A poll arrived that no copy asked for: qid %h src_port %h",
				poll_qid, poll_src_port);
		end else begin
			p = exp_poll.pop_front();
			note(name, {poll_qid, poll_src_port} == p, 64'(p), 64'({poll_qid, poll_src_port}));
		end
	endtask

	task automatic check_enq();
		tm_enq_t e;
		string   name;
		if (exp_enq.size() == 0) begin
			fail_count++;
			$display("An enqueue arrived that no test expected: %h", tm_enq);
		end else begin
			e    = exp_enq.pop_front();
			name = enq_name.pop_front();
			if (!ack_hist[2]) begin
				fail_count++;
				$display("Error %s: enqueue not 3 cycles after poll_ack, expected 1 actual 0",
					name);
			end else begin
				note(name, tm_enq == e, 64'(e), 64'(tm_enq));
			end
		end
	endtask

	task automatic check_release();
		release_t r;
		if (exp_rel.size() == 0) begin
			fail_count++;
			$display("A buffer release arrived that no test expected: %h", release_data);
		end else begin
			r = exp_rel.pop_front();
			note(rel_name.pop_front(), release_data == r, 64'(r), 64'(release_data));
		end
	endtask

	// Outputs are sampled on the falling edge, half a cycle after they change.
	initial begin
		int missing;
		pass_count    = 0;
		fail_count    = 0;
		report_done   = 1'b0;
		polls_checked = 0;
		ack_hist      = '0;
		disc_hist     = '0;
		bp_seen       = 1'b0;
		load_expected();
		forever begin
			@(negedge clk);
			if (rst_n) begin
				if (poll_req) begin
					compare_poll();
				end
				if (tm_enq_req) begin
					check_enq();
				end
				if (release_valid) begin
					check_release();
				end
				if (disc_hist[1] && !release_valid) begin
					fail_count++;
					$display("No buffer release came out 2 cycles after a discard request.");
				end
				if (rep_bp) begin
					bp_seen = 1'b1;
				end
				if (bp_check && bp_name.size() > 0) begin
					note(bp_name.pop_front(), bp_seen && !rep_bp, 64'(2'b10),
						64'({bp_seen, rep_bp}));
				end
				ack_hist  = {ack_hist[1:0], poll_ack};
				disc_hist = {disc_hist[0], discard_req};
				if (report_req && !report_done) begin
					missing = exp_poll.size() + exp_enq.size() + exp_rel.size() +
						bp_name.size();
					if (missing > 0) begin
						fail_count += missing;
						$display("%0d expected events never occurred.", missing);
					end
					$display("Checks: %0d passed, %0d failed", pass_count, fail_count);
					report_done = 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* asa_golden.txt */
# C pid qid ucast last drop src buf len ack_delay ack_drop conn cgrp pq port (hex)
# D sync rc src buf len | W cycles | B name | E name qid conn cgrp pq src dst buf len | R name rc src buf len
C 05 14 0 0 1 1 100 40 0 0 001 01 01 1
C 05 14 0 0 1 1 100 40 0 0 001 01 01 1
C 05 14 0 0 1 1 100 40 0 0 001 01 01 1
C 05 14 0 0 1 1 100 40 0 0 001 01 01 1
C 05 14 0 0 1 1 100 40 0 0 001 01 01 1
C 05 14 0 0 1 1 100 40 0 0 001 01 01 1
C 05 14 0 0 1 1 100 40 0 0 001 01 01 1
C 05 14 0 0 1 1 100 40 0 0 001 01 01 1
C 05 14 0 0 1 1 100 40 0 0 001 01 01 1
C 05 14 0 0 1 1 100 40 0 0 001 01 01 1
C 05 14 0 0 1 1 100 40 0 0 001 01 01 1
C 05 14 0 0 1 1 100 40 0 0 001 01 01 1
C 05 14 0 0 1 1 100 40 0 0 001 01 01 1
C 05 14 0 1 1 1 100 40 0 0 001 01 01 1
R burst_release 0 1 100 40
B bp_level
C 01 07 1 0 0 2 010 64 2 0 155 09 03 6
E uc_enq 07 155 09 03 2 6 010 64
R uc_release 1 2 010 64
W 14
C 02 1e 0 0 0 3 200 1f4 1 0 011 01 01 1
C 02 1e 0 0 0 3 200 1f4 0 1 022 02 02 2
C 02 1e 0 0 1 3 200 1f4 2 0 033 03 03 3
C 02 1e 0 1 0 3 200 1f4 0 0 044 04 04 4
E mc_enq_a 1e 011 01 01 3 1 200 1f4
E mc_enq_b 1e 044 04 04 3 4 200 1f4
R mc_release 2 3 200 1f4
W 14
C 09 2a 0 0 0 4 300 80 0 0 101 11 05 7
C 09 2a 0 0 0 4 300 80 0 0 102 12 06 8
C 09 2a 0 1 0 4 300 80 0 0 103 13 07 9
C 09 2b 1 0 0 4 310 90 0 0 104 14 08 a
E fwd_enq_a 2a 101 11 05 4 7 300 80
E fwd_enq_b 2a 102 12 06 4 8 300 80
E fwd_enq_c 2a 103 13 07 4 9 300 80
E reuse_enq 2b 104 14 08 4 a 310 90
R fwd_release 3 4 300 80
R reuse_release 1 4 310 90
W 14
C 0c 33 1 0 0 6 500 20 1 0 3ff 3f 1f f
D 1 7 5 444 28
E disc_path_enq 33 3ff 3f 1f 6 f 500 20
R disc_release 0 5 444 28
R disc_queued 1 6 500 20

/* asa_tm_interface.sv */
// Top level of the replication to traffic manager adapter.
// Connects the intake, the read-count stage and the release output.

`default_nettype none

module asa_tm_interface (
	input  wire logic                             clk,
	input  wire logic                             rst_n,
	input  wire logic                             rep_enq_req,
	input  wire asa_types_pkg::rep_copy_t         rep_enq,
	output logic                                  rep_bp,
	output logic                                  poll_req,
	output logic [asa_cfg_pkg::QID_NBITS-1:0]     poll_qid,
	output logic [asa_cfg_pkg::PORT_ID_NBITS-1:0] poll_src_port,
	input  wire logic                             poll_ack,
	input  wire asa_types_pkg::poll_ack_t         poll_ack_data,
	output logic                                  tm_enq_req,
	output asa_types_pkg::tm_enq_t                tm_enq,
	input  wire logic                             discard_req,
	input  wire asa_types_pkg::release_t          discard,
	output logic                                  release_valid,
	output asa_types_pkg::release_t               release_data
);

	import asa_types_pkg::*;

	logic      sweep_done;
	logic      ack_valid;
	rep_copy_t ack_copy;
	poll_ack_t ack_data;
	logic      final_valid;
	release_t  final_release;

	enq_intake u_enq_intake (
		.clk           (clk),
		.rst_n         (rst_n),
		.rep_enq_req   (rep_enq_req),
		.rep_enq       (rep_enq),
		.sweep_done    (sweep_done),
		.poll_ack      (poll_ack),
		.poll_ack_data (poll_ack_data),
		.rep_bp        (rep_bp),
		.poll_req      (poll_req),
		.poll_qid      (poll_qid),
		.poll_src_port (poll_src_port),
		.ack_valid     (ack_valid),
		.ack_copy      (ack_copy),
		.ack_data      (ack_data)
	);

	read_count_stage u_read_count_stage (
		.clk           (clk),
		.rst_n         (rst_n),
		.ack_valid     (ack_valid),
		.ack_copy      (ack_copy),
		.ack_data      (ack_data),
		.sweep_done    (sweep_done),
		.tm_enq_req    (tm_enq_req),
		.tm_enq        (tm_enq),
		.final_valid   (final_valid),
		.final_release (final_release)
	);

	release_mux u_release_mux (
		.clk           (clk),
		.rst_n         (rst_n),
		.discard_req   (discard_req),
		.discard       (discard),
		.final_valid   (final_valid),
		.final_release (final_release),
		.release_valid (release_valid),
		.release_data  (release_data)
	);

endmodule

`default_nettype wire

/* asa_types_pkg.sv */
// Packed struct types that pass between the adapter stages.
// Packet descriptor, replicated copy, poll acknowledgement,
// traffic manager enqueue and buffer release.

`default_nettype none

package asa_types_pkg;

	import asa_cfg_pkg::*;

	// ==================================================
	// Packet descriptor
	// ==================================================
	typedef struct packed {
		logic [PORT_ID_NBITS-1:0]       src_port;
		logic [PORT_ID_NBITS-1:0]       dst_port;
		logic [BUF_PTR_NBITS-1:0]       buf_ptr;
		logic [PACKET_LENGTH_NBITS-1:0] length;
	} pkt_desc_t;

	// One copy from the replicator.
	typedef struct packed {
		logic [PACKET_ID_NBITS-1:0] packet_id;
		logic [QID_NBITS-1:0]       qid;
		logic                       ucast;
		logic                       last;   // Final copy of a multicast packet.
		logic                       drop;
		pkt_desc_t                  desc;
	} rep_copy_t;

	// Answer of the traffic manager to one poll.
	typedef struct packed {
		logic                        drop;
		logic [CONN_ID_NBITS-1:0]    conn_id;
		logic [CONN_GROUP_NBITS-1:0] conn_group_id;
		logic [PORT_QUEUE_NBITS-1:0] port_queue_id;
		logic [PORT_ID_NBITS-1:0]    port_id;
	} poll_ack_t;

	// ==================================================
	// Outgoing requests
	// ==================================================
	typedef struct packed {
		logic [QID_NBITS-1:0]        qid;
		logic [CONN_ID_NBITS-1:0]    conn_id;
		logic [CONN_GROUP_NBITS-1:0] conn_group_id;
		logic [PORT_QUEUE_NBITS-1:0] port_queue_id;
		pkt_desc_t                   desc;
	} tm_enq_t;

	typedef struct packed {
		logic [READ_COUNT_NBITS-1:0]    read_count;
		logic [PORT_ID_NBITS-1:0]       src_port;
		logic [BUF_PTR_NBITS-1:0]       buf_ptr;
		logic [PACKET_LENGTH_NBITS-1:0] length;
	} release_t;

endpackage

`default_nettype wire

/* enq_intake.sv */
// Replication intake queue with hysteresis back-pressure.
// Poll issue to the traffic manager and the queue of copies awaiting an answer.

`default_nettype none

module enq_intake (
	input  wire logic                             clk,
	input  wire logic                             rst_n,
	input  wire logic                             rep_enq_req,
	input  wire asa_types_pkg::rep_copy_t         rep_enq,
	input  wire logic                             sweep_done,
	input  wire logic                             poll_ack,
	input  wire asa_types_pkg::poll_ack_t         poll_ack_data,
	output logic                                  rep_bp,
	output logic                                  poll_req,
	output logic [asa_cfg_pkg::QID_NBITS-1:0]     poll_qid,
	output logic [asa_cfg_pkg::PORT_ID_NBITS-1:0] poll_src_port,
	output logic                                  ack_valid,
	output asa_types_pkg::rep_copy_t              ack_copy,
	output asa_types_pkg::poll_ack_t              ack_data
);

	import asa_cfg_pkg::*;
	import asa_types_pkg::*;

	logic                        rep_enq_req_d1;
	rep_copy_t                   rep_enq_d1;
	rep_copy_t                   intake_head;
	logic                        intake_empty;
	logic [INTAKE_DEPTH_NBITS:0] intake_count;
	logic                        intake_rd;

	assign intake_rd = ~intake_empty & sweep_done;  // Hold polls until the table is clear.

	sync_fifo #(
		.payload_t   (rep_copy_t),
		.DEPTH_NBITS (INTAKE_DEPTH_NBITS)
	) u_intake_fifo (
		.clk   (clk),
		.rst_n (rst_n),
		.wr    (rep_enq_req_d1),
		.din   (rep_enq_d1),
		.rd    (intake_rd),
		.dout  (intake_head),
		.empty (intake_empty),
		.count (intake_count)
	);

	// Each polled copy waits here for its answer. Answers come back in poll order.
	sync_fifo #(
		.payload_t   (rep_copy_t),
		.DEPTH_NBITS (PENDING_DEPTH_NBITS)
	) u_pending_fifo (
		.clk   (clk),
		.rst_n (rst_n),
		.wr    (intake_rd),
		.din   (intake_head),
		.rd    (ack_valid),
		.dout  (ack_copy),
		.empty (),
		.count ()
	);

	always_ff @(posedge clk) begin
		rep_enq_d1    <= rep_enq;
		poll_qid      <= intake_head.qid;
		poll_src_port <= intake_head.desc.src_port;
		ack_data      <= poll_ack_data;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rep_enq_req_d1 <= 1'b0;
			poll_req       <= 1'b0;
			ack_valid      <= 1'b0;
			rep_bp         <= 1'b0;
		end else begin
			rep_enq_req_d1 <= rep_enq_req;
			poll_req       <= intake_rd;
			ack_valid      <= poll_ack;
			if (intake_count > BP_ON_LEVEL) begin
				rep_bp <= 1'b1;
			end else if (intake_count < BP_OFF_LEVEL) begin
				rep_bp <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

/* flist.f */
asa_cfg_pkg.sv
asa_types_pkg.sv
sync_fifo.sv
enq_intake.sv
read_count_stage.sv
release_mux.sv
asa_tm_interface.sv
asa_checker.sv
tb_asa_tm_interface.sv

/* read_count_stage.sv */
// Per-packet read-count table with its reset-time clear sweep.
// Write-forwarding for back-to-back copies, acknowledgement merge,
// enqueue generation and the release of final copies.

`default_nettype none

module read_count_stage (
	input  wire logic                     clk,
	input  wire logic                     rst_n,
	input  wire logic                     ack_valid,
	input  wire asa_types_pkg::rep_copy_t ack_copy,
	input  wire asa_types_pkg::poll_ack_t ack_data,
	output logic                          sweep_done,
	output logic                          tm_enq_req,
	output asa_types_pkg::tm_enq_t        tm_enq,
	output logic                          final_valid,
	output asa_types_pkg::release_t       final_release
);

	import asa_cfg_pkg::*;
	import asa_types_pkg::*;

	localparam int RC_DEPTH = 1 << PACKET_ID_NBITS;

	logic [READ_COUNT_NBITS-1:0] rc_ram [RC_DEPTH];
	logic [PACKET_ID_NBITS-1:0]  sweep_addr;

	logic                        s1_valid;
	rep_copy_t                   s1_copy;
	poll_ack_t                   s1_ack;
	logic                        s1_drop;
	logic [READ_COUNT_NBITS-1:0] s1_rdata;

	logic                        is_final;
	logic [READ_COUNT_NBITS-1:0] old_count;
	logic [READ_COUNT_NBITS-1:0] new_count;
	tm_enq_t                     enq_next;
	release_t                    rel_next;

	logic                        wb_wr;
	logic [PACKET_ID_NBITS-1:0]  wb_addr;
	logic [READ_COUNT_NBITS-1:0] wb_data;
	logic                        wb_wr_d1;
	logic [PACKET_ID_NBITS-1:0]  wb_addr_d1;
	logic [READ_COUNT_NBITS-1:0] wb_data_d1;

	// ==================================================
	// Table clear and RAM
	// ==================================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sweep_addr <= '0;
			sweep_done <= 1'b0;
		end else if (!sweep_done) begin
			sweep_addr <= sweep_addr + 1'b1;
			sweep_done <= &sweep_addr;  // Last entry written this cycle.
		end
	end

	always_ff @(posedge clk) begin
		if (!sweep_done) begin
			rc_ram[sweep_addr] <= '0;
		end else if (wb_wr) begin
			rc_ram[wb_addr] <= wb_data;
		end
		s1_rdata <= rc_ram[ack_copy.packet_id];
	end

	// ==================================================
	// Count update and merge
	// ==================================================
	always_comb begin
		is_final = s1_copy.ucast | s1_copy.last;
		// The two newest writes have not reached the value read from the RAM.
		if (wb_wr && wb_addr == s1_copy.packet_id) begin
			old_count = wb_data;
		end else if (wb_wr_d1 && wb_addr_d1 == s1_copy.packet_id) begin
			old_count = wb_data_d1;
		end else begin
			old_count = s1_rdata;
		end
		new_count = old_count + {{(READ_COUNT_NBITS-1){1'b0}}, ~s1_drop};

		enq_next.qid           = s1_copy.qid;
		enq_next.conn_id       = s1_ack.conn_id;
		enq_next.conn_group_id = s1_ack.conn_group_id;
		enq_next.port_queue_id = s1_ack.port_queue_id;
		enq_next.desc          = s1_copy.desc;
		enq_next.desc.dst_port = s1_ack.port_id;

		rel_next.read_count = new_count;
		rel_next.src_port   = s1_copy.desc.src_port;
		rel_next.buf_ptr    = s1_copy.desc.buf_ptr;
		rel_next.length     = s1_copy.desc.length;
	end

	always_ff @(posedge clk) begin
		s1_copy       <= ack_copy;
		s1_ack        <= ack_data;
		s1_drop       <= ack_copy.drop | ack_data.drop;
		wb_addr       <= s1_copy.packet_id;
		wb_data       <= is_final ? '0 : new_count;  // The next packet on this id starts at zero.
		wb_addr_d1    <= wb_addr;
		wb_data_d1    <= wb_data;
		tm_enq        <= enq_next;
		final_release <= rel_next;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			s1_valid    <= 1'b0;
			wb_wr       <= 1'b0;
			wb_wr_d1    <= 1'b0;
			tm_enq_req  <= 1'b0;
			final_valid <= 1'b0;
		end else begin
			s1_valid    <= ack_valid;
			wb_wr       <= s1_valid;
			wb_wr_d1    <= wb_wr;
			tm_enq_req  <= s1_valid & ~s1_drop;
			final_valid <= s1_valid & is_final;
		end
	end

endmodule

`default_nettype wire

/* release_mux.sv */
// Release queue and the buffer manager output.
// A registered discard takes the output cycle ahead of queued releases.

`default_nettype none

module release_mux (
	input  wire logic                     clk,
	input  wire logic                     rst_n,
	input  wire logic                     discard_req,
	input  wire asa_types_pkg::release_t  discard,
	input  wire logic                     final_valid,
	input  wire asa_types_pkg::release_t  final_release,
	output logic                          release_valid,
	output asa_types_pkg::release_t       release_data
);

	import asa_cfg_pkg::*;
	import asa_types_pkg::*;

	logic     discard_req_d1;
	release_t discard_d1;
	release_t discard_out;
	release_t queue_head;
	logic     queue_empty;
	logic     queue_rd;

	assign queue_rd = ~discard_req_d1 & ~queue_empty;

	always_comb begin
		discard_out            = discard_d1;
		discard_out.read_count = '0;  // No copy of a discarded packet was enqueued.
	end

	sync_fifo #(
		.payload_t   (release_t),
		.DEPTH_NBITS (RELEASE_DEPTH_NBITS)
	) u_release_fifo (
		.clk   (clk),
		.rst_n (rst_n),
		.wr    (final_valid),
		.din   (final_release),
		.rd    (queue_rd),
		.dout  (queue_head),
		.empty (queue_empty),
		.count ()
	);

	always_ff @(posedge clk) begin
		discard_d1   <= discard;
		release_data <= discard_req_d1 ? discard_out : queue_head;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			discard_req_d1 <= 1'b0;
			release_valid  <= 1'b0;
		end else begin
			discard_req_d1 <= discard_req;
			release_valid  <= discard_req_d1 | ~queue_empty;
		end
	end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build and run the adapter testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_asa_tm_interface \
	-f flist.f -o sim_asa

./obj_dir/sim_asa > sim.log 2>&1 || true
cat sim.log

if grep -q "Test passed" sim.log; then
	exit 0
else
	echo "Simulation did not pass, see sim.log"
	exit 1
fi

/* sync_fifo.sv */
// Synchronous first-word-fall-through queue.
// Register array with read and write pointers and an occupancy count.

`default_nettype none

module sync_fifo #(
	parameter type payload_t   = logic,
	parameter int  DEPTH_NBITS = 4
) (
	input  wire logic           clk,
	input  wire logic           rst_n,
	input  wire logic           wr,
	input  wire payload_t       din,
	input  wire logic           rd,
	output payload_t            dout,
	output logic                empty,
	output logic [DEPTH_NBITS:0] count
);

	localparam int DEPTH = 1 << DEPTH_NBITS;

	payload_t               mem [DEPTH];
	logic [DEPTH_NBITS-1:0] wr_ptr;
	logic [DEPTH_NBITS-1:0] rd_ptr;
	logic                   full;
	logic                   do_wr;
	logic                   do_rd;

	assign empty = (count == '0);
	assign full  = count[DEPTH_NBITS];
	assign do_rd = rd & ~empty;
	assign do_wr = wr & (~full | do_rd);  // A read in the same cycle frees the slot.
	assign dout  = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_wr) begin
			mem[wr_ptr] <= din;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_rd) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_wr, do_rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

/* tb_asa_tm_interface.sv */
// Testbench top for the replication to traffic manager adapter.
// Clock, reset, stimulus from the golden file, the traffic manager
// responder and the watchdog.

`default_nettype none

module tb_asa_tm_interface;

	import asa_cfg_pkg::*;
	import asa_types_pkg::*;

	localparam int NFIELDS = 15;  // Field slots stored per stimulus record.

	logic                     clk;
	logic                     rst_n;
	logic                     rep_enq_req;
	rep_copy_t                rep_enq;
	logic                     rep_bp;
	logic                     poll_req;
	logic [QID_NBITS-1:0]     poll_qid;
	logic [PORT_ID_NBITS-1:0] poll_src_port;
	logic                     poll_ack;
	poll_ack_t                poll_ack_data;
	logic                     tm_enq_req;
	tm_enq_t                  tm_enq;
	logic                     discard_req;
	release_t                 discard;
	logic                     release_valid;
	release_t                 release_data;

	logic bp_check;
	logic report_req;
	logic report_done;
	int   pass_count;
	int   fail_count;

	string     rec_kind[$];
	int        rec_field[$];
	int        n_records;
	logic      load_done;
	poll_ack_t ack_plan[$];
	int        ack_delay_plan[$];
	poll_ack_t ack_wait[$];
	int        ack_due[$];
	int        copies_sent;
	int        polls_seen;

	asa_tm_interface u_asa_tm_interface (
		.clk           (clk),
		.rst_n         (rst_n),
		.rep_enq_req   (rep_enq_req),
		.rep_enq       (rep_enq),
		.rep_bp        (rep_bp),
		.poll_req      (poll_req),
		.poll_qid      (poll_qid),
		.poll_src_port (poll_src_port),
		.poll_ack      (poll_ack),
		.poll_ack_data (poll_ack_data),
		.tm_enq_req    (tm_enq_req),
		.tm_enq        (tm_enq),
		.discard_req   (discard_req),
		.discard       (discard),
		.release_valid (release_valid),
		.release_data  (release_data)
	);

	asa_checker u_checker (
		.clk           (clk),
		.rst_n         (rst_n),
		.poll_req      (poll_req),
		.poll_qid      (poll_qid),
		.poll_src_port (poll_src_port),
		.tm_enq_req    (tm_enq_req),
		.tm_enq        (tm_enq),
		.release_valid (release_valid),
		.release_data  (release_data),
		.poll_ack      (poll_ack),
		.discard_req   (discard_req),
		.rep_bp        (rep_bp),
		.bp_check      (bp_check),
		.report_req    (report_req),
		.report_done   (report_done),
		.pass_count    (pass_count),
		.fail_count    (fail_count)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ==================================================
	// Golden file stimulus
	// ==================================================
	task automatic load_stimulus();
		int    fd;
		int    code;
		int    nf;
		int    v;
		string tok;
		string rest;
		fd = $fopen("asa_golden.txt", "r");
		if (fd == 0) begin
			$display("Cannot open asa_golden.txt for reading.");
			return;
		end
		while (!$feof(fd)) begin
			code = $fscanf(fd, "%s", tok);
			if (code != 1) begin
				break;
			end
			if (tok == "C" || tok == "D" || tok == "W" || tok == "B") begin
				nf = (tok == "C") ? 14 : (tok == "D") ? 5 : (tok == "W") ? 1 : 0;
				rec_kind.push_back(tok);
				for (int i = 0; i < NFIELDS; i++) begin
					v = 0;
					if (i < nf) begin
						code = $fscanf(fd, "%h", v);
					end
					rec_field.push_back(v);
				end
				if (tok == "B") begin
					code = $fgets(rest, fd);
				end
			end else begin
				code = $fgets(rest, fd);  // Comments and expected lines.
			end
		end
		$fclose(fd);
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#10;
	endtask

	task automatic drive_copy(input int base);
		rep_copy_t c;
		poll_ack_t a;
		c                = '0;
		c.packet_id      = PACKET_ID_NBITS'(rec_field[base]);
		c.qid            = QID_NBITS'(rec_field[base+1]);
		c.ucast          = 1'(rec_field[base+2]);
		c.last           = 1'(rec_field[base+3]);
		c.drop           = 1'(rec_field[base+4]);
		c.desc.src_port  = PORT_ID_NBITS'(rec_field[base+5]);
		c.desc.buf_ptr   = BUF_PTR_NBITS'(rec_field[base+6]);
		c.desc.length    = PACKET_LENGTH_NBITS'(rec_field[base+7]);
		a.drop           = 1'(rec_field[base+9]);
		a.conn_id        = CONN_ID_NBITS'(rec_field[base+10]);
		a.conn_group_id  = CONN_GROUP_NBITS'(rec_field[base+11]);
		a.port_queue_id  = PORT_QUEUE_NBITS'(rec_field[base+12]);
		a.port_id        = PORT_ID_NBITS'(rec_field[base+13]);
		ack_plan.push_back(a);
		ack_delay_plan.push_back(rec_field[base+8]);
		rep_enq     = c;
		rep_enq_req = 1'b1;
		copies_sent++;
		next_cycle();
		rep_enq_req = 1'b0;
	endtask

	task automatic drive_discard(input int base);
		release_t d;
		d.read_count = READ_COUNT_NBITS'(rec_field[base+1]);
		d.src_port   = PORT_ID_NBITS'(rec_field[base+2]);
		d.buf_ptr    = BUF_PTR_NBITS'(rec_field[base+3]);
		d.length     = PACKET_LENGTH_NBITS'(rec_field[base+4]);
		// Align with an enqueue so the discard meets the matching queued release.
		if (rec_field[base] != 0) begin
			while (!tm_enq_req) begin
				next_cycle();
			end
		end
		discard     = d;
		discard_req = 1'b1;
		next_cycle();
		discard_req = 1'b0;
	endtask

	task automatic wait_idle();
		while (polls_seen < copies_sent || ack_wait.size() > 0) begin
			next_cycle();
		end
		repeat (20) next_cycle();
	endtask

	initial begin : main
		int    base;
		string k;
		rst_n       = 1'b0;
		rep_enq_req = 1'b0;
		rep_enq     = '0;
		discard_req = 1'b0;
		discard     = '0;
		bp_check    = 1'b0;
		report_req  = 1'b0;
		copies_sent = 0;
		load_done   = 1'b0;
		load_stimulus();
		n_records = rec_kind.size();
		load_done = 1'b1;
		repeat (3) @(posedge clk);
		#10;
		rst_n = 1'b1;
		for (int r = 0; r < n_records; r++) begin
			base = r * NFIELDS;
			k    = rec_kind[r];
			if (k == "C") begin
				drive_copy(base);
			end else if (k == "D") begin
				drive_discard(base);
			end else if (k == "W") begin
				repeat (rec_field[base]) next_cycle();
			end else begin
				wait_idle();
				bp_check = 1'b1;
				next_cycle();
				bp_check = 1'b0;
			end
		end
		wait_idle();
		report_req = 1'b1;
		wait (report_done);
		if (fail_count == 0 && pass_count > 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	// ==================================================
	// Traffic manager responder and watchdog
	// ==================================================
	initial begin : responder
		int now;
		now           = 0;
		polls_seen    = 0;
		poll_ack      = 1'b0;
		poll_ack_data = '0;
		forever begin
			next_cycle();
			now++;
			poll_ack = 1'b0;
			if (rst_n && poll_req && ack_plan.size() > 0) begin
				ack_wait.push_back(ack_plan.pop_front());
				ack_due.push_back(now + ack_delay_plan.pop_front());
				polls_seen++;
			end
			// One answer per cycle, in poll order.
			if (ack_wait.size() > 0 && ack_due[0] <= now) begin
				poll_ack      = 1'b1;
				poll_ack_data = ack_wait.pop_front();
				void'(ack_due.pop_front());
			end
		end
	end

	initial begin : watchdog
		wait (load_done);
		repeat (200 * n_records + 500) @(posedge clk);
		$display("Timeout: the DUT did not finish the stimulus in time.");
		$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire
